// File: hdl/isa_pkg.sv
package isa_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] shamt_t;
	typedef logic [5:0] inst_num_t;

	localparam inst_num_t op_add = 6'd8;
	localparam inst_num_t op_addi = 6'd9;
	localparam inst_num_t op_sub = 6'd10;
	localparam inst_num_t op_lui = 6'd11;
	localparam inst_num_t op_div = 6'd12;
	localparam inst_num_t op_mult = 6'd13;
	localparam inst_num_t op_divi = 6'd14;
	localparam inst_num_t op_multi = 6'd15;
	localparam inst_num_t op_sll = 6'd16;
	localparam inst_num_t op_sra = 6'd17;
	localparam inst_num_t op_srl = 6'd18;
	localparam inst_num_t op_and = 6'd20;
	localparam inst_num_t op_andi = 6'd21;
	localparam inst_num_t op_or = 6'd22;
	localparam inst_num_t op_ori = 6'd23;
	localparam inst_num_t op_xor = 6'd24;
	localparam inst_num_t op_xori = 6'd25;
	localparam inst_num_t op_nor = 6'd26;

	// Shift selection from element to shifter
	typedef enum logic [1:0] {
		shift_none,
		shift_left,
		shift_right_arith,
		shift_right_logic
	} shift_kind_t;

endpackage

// File: hdl/exec_pkg.sv
package exec_pkg;

	import isa_pkg::*;

	typedef logic [3:0] tag_t;

	typedef struct packed {
		inst_num_t inst_num;
		word_t rs;
		word_t rt;
		word_t const16_x; // Already extended
		shamt_t shift5;
		tag_t tag;
	} exec_req_t;

	typedef struct packed {
		tag_t tag;
		word_t result;
	} exec_rsp_t;

	typedef enum logic {
		idle,
		busy
	} ctrl_state_t;

endpackage

// File: hdl/divider.sv
module divider import isa_pkg::*; (
	input logic clk,
	input logic reset,
	input logic start,
	input word_t dividend,
	input word_t divisor,
	output logic done,
	output word_t quotient
);

	word_t remainder;
	word_t divisor_q;
	logic running;
	logic [4:0] iteration;
	logic [32:0] partial;
	logic [33:0] trial;

	// Shift in next dividend bit and try the subtraction
	always_comb begin
		partial = {remainder, quotient[31]};
		trial = {1'b0, partial} - {2'b00, divisor_q};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			iteration <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				running <= 1'b1;
				iteration <= '0;
			end else if (running) begin
				iteration <= iteration + 5'd1;
				if (iteration == 5'd31) begin // Last quotient bit
					running <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			remainder <= '0;
			quotient <= dividend;
			divisor_q <= divisor;
		end else if (running) begin
			if (!trial[33]) begin // No borrow, keep difference
				remainder <= trial[31:0];
				quotient <= {quotient[30:0], 1'b1};
			end else begin // Restore
				remainder <= partial[31:0];
				quotient <= {quotient[30:0], 1'b0};
			end
		end
	end

endmodule

// File: hdl/barrel_shifter.sv
module barrel_shifter import isa_pkg::*; (
	input word_t value,
	input shamt_t amount,
	input shift_kind_t kind,
	output word_t shifted
);

	word_t stage [6];
	logic fill;

	always_comb begin
		stage[0] = value;
		fill = (kind == shift_right_arith) ? value[31] : 1'b0; // Original sign bit
	end

	for (genvar i = 0; i < 5; i++) begin : g_stage
		always_comb begin
			if (amount[i]) begin
				case (kind)
					shift_left:
						stage[i + 1] = {stage[i][31 - 2**i:0], {(2**i){1'b0}}};
					shift_right_arith, shift_right_logic:
						stage[i + 1] = {{(2**i){fill}}, stage[i][31:2**i]};
					default:
						stage[i + 1] = stage[i];
				endcase
			end else begin
				stage[i + 1] = stage[i];
			end
		end
	end

	assign shifted = stage[5];

endmodule

// File: hdl/alu_exec_element.sv
module alu_exec_element import isa_pkg::*, exec_pkg::*; (
	input logic clk,
	input logic reset,
	input logic start,
	input exec_req_t op,
	output logic done,
	output word_t result
);

	word_t operand_b;
	word_t alu_value;
	word_t mul_product; // Low half of signed product
	word_t quotient;
	word_t shifted;
	shift_kind_t kind;
	logic is_div;
	logic is_mult;
	logic div_start;
	logic div_done;
	logic mul_pending;
	logic div_pending;

	always_comb begin
		is_div = (op.inst_num == op_div) || (op.inst_num == op_divi);
		is_mult = (op.inst_num == op_mult) || (op.inst_num == op_multi);
		if ((op.inst_num == op_divi) || (op.inst_num == op_multi))
			operand_b = op.const16_x;
		else
			operand_b = op.rt;
		div_start = start && is_div;
	end

	always_comb begin
		case (op.inst_num)
			op_sll: kind = shift_left;
			op_sra: kind = shift_right_arith;
			op_srl: kind = shift_right_logic;
			default: kind = shift_none;
		endcase
	end

	divider u_divider (
		.clk(clk),
		.reset(reset),
		.start(div_start),
		.dividend(op.rs),
		.divisor(operand_b),
		.done(div_done),
		.quotient(quotient)
	);

	barrel_shifter u_shifter (
		.value(op.rs),
		.amount(op.shift5),
		.kind(kind),
		.shifted(shifted)
	);

	always_comb begin
		case (op.inst_num)
			op_add: alu_value = op.rs + op.rt;
			op_addi: alu_value = op.rs + op.const16_x;
			op_sub: alu_value = op.rs - op.rt;
			op_lui: alu_value = {op.const16_x[15:0], 16'h0000};
			op_sll, op_sra, op_srl: alu_value = shifted;
			op_and: alu_value = op.rs & op.rt;
			op_andi: alu_value = {16'h0000, op.rs[15:0] & op.const16_x[15:0]};
			op_or: alu_value = op.rs | op.rt;
			op_ori: alu_value = {op.rs[31:16], op.rs[15:0] | op.const16_x[15:0]};
			op_xor: alu_value = op.rs ^ op.rt;
			op_xori: alu_value = {op.rs[31:16], op.rs[15:0] ^ op.const16_x[15:0]};
			op_nor: alu_value = ~(op.rs | op.rt);
			default: alu_value = '0; // Unknown opcode
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			done <= 1'b0;
			mul_pending <= 1'b0;
			div_pending <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				if (is_div) begin
					div_pending <= 1'b1;
				end else if (is_mult) begin
					mul_pending <= 1'b1;
				end else begin
					done <= 1'b1;
				end
			end else if (mul_pending) begin
				mul_pending <= 1'b0;
				done <= 1'b1;
			end else if (div_pending && div_done) begin
				div_pending <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start && is_mult)
			mul_product <= word_t'($signed(op.rs) * $signed(operand_b));
		if (start && !is_div && !is_mult)
			result <= alu_value;
		else if (mul_pending)
			result <= mul_product;
		else if (div_pending && div_done)
			result <= quotient;
	end

endmodule

// File: hdl/exec_control.sv
module exec_control import isa_pkg::*, exec_pkg::*; #(
	parameter int QUEUE_DEPTH = 4,
	parameter int RSP_CREDITS = 2
) (
	input logic clk,
	input logic reset,
	input logic req_valid,
	input exec_req_t req,
	output logic req_credit,
	input logic rsp_credit,
	output logic start,
	output exec_req_t op,
	input logic done,
	input word_t result,
	output logic rsp_valid,
	output exec_rsp_t rsp
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
	localparam int CRED_W = $clog2(RSP_CREDITS + 1);

	exec_req_t queue [QUEUE_DEPTH];
	exec_req_t op_q; // Operation in service
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] fill;
	logic [CRED_W-1:0] credit_count;
	ctrl_state_t state;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign start = (state == idle) && (fill != '0) && (credit_count != '0);
	assign req_credit = start; // Slot freed by the pop
	assign op = (state == busy) ? op_q : queue[rd_ptr];

	always_ff @(posedge clk) begin
		if (req_valid)
			queue[wr_ptr] <= req; // Upstream only sends against credits
		if (start)
			op_q <= queue[rd_ptr];
		if (done)
			rsp <= '{tag: op_q.tag, result: result};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
			credit_count <= CRED_W'(RSP_CREDITS);
			state <= idle;
			rsp_valid <= 1'b0;
		end else begin
			if (req_valid)
				wr_ptr <= next_ptr(wr_ptr);
			if (start)
				rd_ptr <= next_ptr(rd_ptr);
			case ({req_valid, start})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
			credit_count <= credit_count - CRED_W'(start) + CRED_W'(rsp_credit);
			case (state)
				idle: if (start) state <= busy;
				busy: if (done) state <= idle;
				default: state <= idle;
			endcase
			rsp_valid <= done;
		end
	end

endmodule

// File: hdl/exec_unit_top.sv
module exec_unit_top import isa_pkg::*, exec_pkg::*; #(
	parameter int QUEUE_DEPTH = 4,
	parameter int RSP_CREDITS = 2
) (
	input logic clk,
	input logic reset,
	input logic req_valid,
	input exec_req_t req,
	output logic req_credit,
	input logic rsp_credit,
	output logic rsp_valid,
	output exec_rsp_t rsp
);

	logic start;
	logic done;
	exec_req_t op;
	word_t result;

	exec_control #(
		.QUEUE_DEPTH(QUEUE_DEPTH),
		.RSP_CREDITS(RSP_CREDITS)
	) u_control (
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req(req),
		.req_credit(req_credit),
		.rsp_credit(rsp_credit),
		.start(start),
		.op(op),
		.done(done),
		.result(result),
		.rsp_valid(rsp_valid),
		.rsp(rsp)
	);

	alu_exec_element u_element (
		.clk(clk),
		.reset(reset),
		.start(start),
		.op(op),
		.done(done),
		.result(result)
	);

endmodule

// File: verification/exec_unit_assertions.sv
module exec_unit_assertions
	import exec_pkg::*;
#(
	parameter int CRED_W = 2,
	parameter int RSP_CREDITS = 2
) (
	input logic clk,
	input logic reset,
	input logic start,
	input logic req_credit,
	input logic done,
	input logic rsp_valid,
	input ctrl_state_t state,
	input logic [CRED_W-1:0] credit_count
);

	timeunit 1ns;
	timeprecision 100ps;

	logic in_service; // Element holds an operation
	int failures = 0;

	always_ff @(posedge clk) begin
		if (reset)
			in_service <= 1'b0;
		else if (start)
			in_service <= 1'b1;
		else if (done)
			in_service <= 1'b0;
	end

	start_only_when_idle: assert property (@(posedge clk) disable iff (reset)
		start |-> !in_service)
		else begin
			failures++;
			$error("Dispatch while the element is busy");
		end

	credit_with_start: assert property (@(posedge clk) disable iff (reset)
		req_credit |=> state == busy)
		else begin
			failures++;
			$error("Slot credit returned without a dispatch");
		end

	dispatch_needs_credit: assert property (@(posedge clk) disable iff (reset)
		start |=> credit_count <= CRED_W'(RSP_CREDITS)) // Wraps past the limit on underflow
		else begin
			failures++;
			$error("Dispatch with no result credit");
		end

	single_cycle_rsp: assert property (@(posedge clk) disable iff (reset)
		rsp_valid |=> !rsp_valid) // One response per done pulse
		else begin
			failures++;
			$error("Response valid held longer than one cycle");
		end

endmodule

bind exec_control exec_unit_assertions #(
	.CRED_W(CRED_W),
	.RSP_CREDITS(RSP_CREDITS)
) u_assertions (
	.clk(clk),
	.reset(reset),
	.start(start),
	.req_credit(req_credit),
	.done(done),
	.rsp_valid(rsp_valid),
	.state(state),
	.credit_count(credit_count)
);

// File: verification/exec_unit_tb.sv
module exec_unit_tb
	import isa_pkg::*, exec_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int QUEUE_DEPTH = 4;
	localparam int RSP_CREDITS = 2;
	localparam int NUM_VECTORS = 40;
	localparam int TIMEOUT_CYCLES = NUM_VECTORS * 40 + 200;

	typedef struct packed {
		inst_num_t opcode;
		word_t rs;
		word_t rt;
		word_t imm;
		shamt_t shamt;
		word_t expected;
	} vector_t;

	logic clk = 1'b0;
	logic reset;
	logic req_valid;
	exec_req_t req;
	logic req_credit;
	logic rsp_credit;
	logic rsp_valid;
	exec_rsp_t rsp;

	vector_t vectors [NUM_VECTORS];
	int vector_count = 0;
	logic [31:0] lcg_state = 32'hbf3b_6841;
	int up_credits = QUEUE_DEPTH; // Queue slots upstream may fill
	int sent = 0;
	int received = 0;
	int owed = 0; // Result credits not yet returned
	logic hold;
	logic sending;

	exec_unit_top #(
		.QUEUE_DEPTH(QUEUE_DEPTH),
		.RSP_CREDITS(RSP_CREDITS)
	) DUT (
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req(req),
		.req_credit(req_credit),
		.rsp_credit(rsp_credit),
		.rsp_valid(rsp_valid),
		.rsp(rsp)
	);

	always #10 clk = ~clk;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "Run stopped on first error");
	endtask

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Expected result from the instruction rules
	function automatic word_t model_result(input inst_num_t opcode, input word_t rs,
			input word_t rt, input word_t imm, input shamt_t shamt);
		logic signed [63:0] product;
		word_t r;
		case (opcode)
			op_add: r = rs + rt;
			op_addi: r = rs + imm;
			op_sub: r = rs - rt;
			op_lui: r = imm << 16;
			op_div: r = (rt == '0) ? '1 : rs / rt;
			op_divi: r = (imm == '0) ? '1 : rs / imm;
			op_mult: begin
				product = $signed(rs) * $signed(rt);
				r = product[31:0];
			end
			op_multi: begin
				product = $signed(rs) * $signed(imm);
				r = product[31:0];
			end
			op_sll: r = rs << shamt;
			op_sra: r = $signed(rs) >>> shamt;
			op_srl: r = rs >> shamt;
			op_and: r = rs & rt;
			op_andi: r = rs & imm & 32'h0000_ffff;
			op_or: r = rs | rt;
			op_ori: r = rs | (imm & 32'h0000_ffff);
			op_xor: r = rs ^ rt;
			op_xori: r = rs ^ (imm & 32'h0000_ffff);
			op_nor: r = ~(rs | rt);
			default: r = '0;
		endcase
		return r;
	endfunction

	task automatic add_vector(input inst_num_t opcode, input word_t rs, input word_t rt,
			input word_t imm, input shamt_t shamt);
		vectors[vector_count] = '{opcode, rs, rt, imm, shamt,
			model_result(opcode, rs, rt, imm, shamt)};
		vector_count++;
	endtask

	task automatic build_table();
		word_t sel;
		word_t rs;
		word_t rt;
		word_t imm;
		add_vector(op_add, 32'h7fff_ffff, 32'h0000_0001, '0, '0);
		add_vector(op_addi, 32'h0000_0010, '0, 32'hffff_fff0, '0);
		add_vector(op_sub, 32'd5, 32'd8, '0, '0);
		add_vector(op_lui, 32'hdead_beef, '0, 32'h0000_1234, '0);
		add_vector(op_and, 32'hf0f0_f0f0, 32'h3c3c_3c3c, '0, '0);
		add_vector(op_andi, 32'hffff_ffff, '0, 32'hffff_8001, '0);
		add_vector(op_or, 32'h1200_0034, 32'h0056_7800, '0, '0);
		add_vector(op_ori, 32'habcd_0000, '0, 32'hffff_00ff, '0);
		add_vector(op_xor, 32'hffff_0000, 32'h0f0f_0f0f, '0, '0);
		add_vector(op_xori, 32'h1234_5678, '0, 32'hffff_ffff, '0);
		add_vector(op_nor, 32'h0000_ffff, 32'h00ff_0000, '0, '0);
		add_vector(6'd19, 32'd1, 32'd1, 32'd1, 5'd1); // Gap in the opcode map
		add_vector(6'd63, 32'hffff_ffff, 32'hffff_ffff, '1, 5'd3);
		add_vector(op_sll, 32'h8000_0001, '0, '0, 5'd0);
		add_vector(op_sll, 32'h0000_0001, '0, '0, 5'd31);
		add_vector(op_sra, 32'h8000_0000, '0, '0, 5'd4);
		add_vector(op_sra, 32'h8765_4321, '0, '0, 5'd31);
		add_vector(op_srl, 32'hffff_ffff, '0, '0, 5'd31);
		add_vector(op_mult, 32'hffff_fffd, 32'd7, '0, '0);
		add_vector(op_multi, 32'h0001_0000, '0, 32'h0001_0000, '0);
		add_vector(op_div, 32'd100, 32'd7, '0, '0);
		add_vector(op_div, 32'hffff_ffff, 32'd3, '0, '0);
		add_vector(op_div, 32'd1234, '0, '0, '0);
		add_vector(op_divi, 32'd1000, '0, 32'hffff_fff6, '0);
		add_vector(op_divi, 32'd77, '0, '0, '0);
		while (vector_count < NUM_VECTORS) begin
			sel = next_random();
			rs = next_random();
			rt = next_random();
			imm = next_random();
			imm = {{16{imm[15]}}, imm[15:0]};
			add_vector(inst_num_t'(8 + sel % 19), rs, rt, imm, shamt_t'(sel >> 8));
		end
	endtask

	// Upstream sender, spends one slot credit per valid cycle
	initial begin
		wait (sending);
		while (sent < NUM_VECTORS) begin
			@(posedge clk);
			#2;
			if (up_credits > 0) begin
				req_valid = 1'b1;
				req = '{vectors[sent].opcode, vectors[sent].rs, vectors[sent].rt,
					vectors[sent].imm, vectors[sent].shamt, tag_t'(sent)};
				up_credits--;
				sent++;
			end else begin
				req_valid = 1'b0;
			end
		end
		@(posedge clk);
		#2 req_valid = 1'b0;
	end

	always @(posedge clk) begin
		#2;
		if (!reset && !hold && owed > 0) begin
			rsp_credit = 1'b1;
			owed--;
		end else begin
			rsp_credit = 1'b0;
		end
	end

	always @(negedge clk) begin
		if (!reset) begin
			assert (DUT.u_control.u_assertions.failures == 0)
				else abort_run("A bound assertion on the credit and dispatch rules failed");
			if (req_credit) begin
				assert (up_credits < QUEUE_DEPTH)
					else abort_run("Slot credit returned while upstream holds all of them");
				up_credits++;
			end
			if (rsp_valid) begin
				assert (received < NUM_VECTORS)
					else abort_run("Response arrived after the last operation completed");
				assert (rsp.tag == tag_t'(received))
					else abort_run($sformatf("FAIL %0d ns: tag order, expected %0d actual %0d",
						$time, tag_t'(received), rsp.tag));
				assert (rsp.result == vectors[received].expected)
					else abort_run($sformatf("FAIL %0d ns: tag %0d expected %h actual %h",
						$time, rsp.tag, vectors[received].expected, rsp.result));
				received++;
				owed++;
				if (hold) begin
					assert (received <= RSP_CREDITS)
						else abort_run("More responses than result credits while withheld");
				end
			end
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		abort_run("Timeout: not all responses arrived in time");
	end

	initial begin
		reset = 1'b1;
		req_valid = 1'b0;
		req = '0;
		rsp_credit = 1'b0;
		hold = 1'b1;
		sending = 1'b0;
		build_table();
		repeat (3) @(posedge clk);
		#2 reset = 1'b0;
		repeat (5) begin
			@(negedge clk);
			assert (!rsp_valid && !req_credit)
				else abort_run("Output pulse seen after reset with no requests");
		end
		sending = 1'b1;
		repeat (60) @(posedge clk); // Result credits withheld
		assert (sent == QUEUE_DEPTH + RSP_CREDITS && up_credits == 0)
			else abort_run("Upstream did not stall on a full queue under back-pressure");
		assert (received == RSP_CREDITS)
			else abort_run("Wrong number of responses while result credits were withheld");
		hold = 1'b0;
		wait (received == NUM_VECTORS);
		repeat (50) @(posedge clk);
		$display("Result: PASSED");
		$finish;
	end

endmodule

// File: project.f
hdl/isa_pkg.sv
hdl/exec_pkg.sv
hdl/divider.sv
hdl/barrel_shifter.sv
hdl/alu_exec_element.sv
hdl/exec_control.sv
hdl/exec_unit_top.sv
verification/exec_unit_assertions.sv
verification/exec_unit_tb.sv
